// File: Bender.yml
package:
  name: decode_front_end

sources:
  - files:
      - verilog/archPkg.sv
      - verilog/pipePkg.sv
      - verilog/registerFile.sv
      - verilog/pipeStage.sv
      - verilog/decodeFrontEnd.sv
  - target: test
    files:
      - verification/decodeFrontEnd_asserts.sv
      - verification/tbDecodeFrontEnd.sv

// File: list.f
verilog/archPkg.sv
verilog/pipePkg.sv
verilog/registerFile.sv
verilog/pipeStage.sv
verilog/decodeFrontEnd.sv
verification/decodeFrontEnd_asserts.sv
verification/tbDecodeFrontEnd.sv

// File: verification/decodeFrontEnd_asserts.sv
//========================================
// concurrent checks on the decode front end
// bound into every decodeFrontEnd instance
//========================================

`timescale 1ns/1ps

module decodeFrontEnd_asserts import archPkg::*, pipePkg::*; #(
  parameter int unsigned pcStep = 4
) (
  input logic    clk,
  input logic    clr,
  input logic    stall,
  input logic    flushDecode,
  input logic    writeEnable,
  input regAddrT writeAddr,
  input wordT    writeData,
  input logic    pcEnable,
  input idExT    decodeOut,
  input logic    decodeValid,
  input wordT    pc
);

  // failed assertions so far
  int failCount = 0;

  // writeback aimed at r15
  logic pcWrite;
  assign pcWrite = writeEnable && (writeAddr == regAddrT'(pcIndex));

  validInReset: assert property (@(posedge clk) !clr |-> !decodeValid)
  else
  begin
    failCount++;
    $error("decodeValid high while in reset");
  end

  // pc load wins over the step
  pcLoad: assert property (@(posedge clk) disable iff (!clr)
    pcWrite |=> (pc == $past(writeData)))
  else
  begin
    failCount++;
    $error("pc did not take the written value");
  end

  pcAdvance: assert property (@(posedge clk) disable iff (!clr)
    (!pcWrite && pcEnable) |=> (pc == $past(pc) + wordT'(pcStep)))
  else
  begin
    failCount++;
    $error("pc did not advance by one step");
  end

  pcHold: assert property (@(posedge clk) disable iff (!clr)
    (!pcWrite && !pcEnable) |=> $stable(pc))
  else
  begin
    failCount++;
    $error("pc moved while neither written nor enabled");
  end

  // stall freezes the output stage
  stallHold: assert property (@(posedge clk) disable iff (!clr)
    (stall && !flushDecode) |=> ($stable(decodeValid) && $stable(decodeOut)))
  else
  begin
    failCount++;
    $error("decode output changed under stall");
  end

endmodule

bind decodeFrontEnd decodeFrontEnd_asserts #(.pcStep(pcStep)) u_asserts (.*);

// File: verification/tbDecodeFrontEnd.sv
//========================================
// testbench for the decode front end
// runs directed and random tests against a cycle model of the two stages
//========================================

`timescale 1ns/1ps

module tbDecodeFrontEnd import archPkg::*, pipePkg::*; ();

  localparam int unsigned pcStep = 4;

  // cycle budget per test
  // the watchdog limit is built from these
  localparam int resetCycles = 5;
  localparam int stepCycles = 12;
  localparam int holdCycles = 4;
  localparam int operandCount = 20;
  localparam int flowCycles = 24;
  localparam int stallCycles = 40;
  localparam int drainCycles = 3;
  localparam int totalCycles = resetCycles + stepCycles + holdCycles + 3 + pcIndex
    + 2 * operandCount + flowCycles + stallCycles + 6 * drainCycles;
  localparam int watchdogCycles = totalCycles + 100;

  logic clk;
  logic clr;
  instrT fetchInstr;
  logic fetchValid;
  ctrlWordT fetchCtrl;
  logic stall;
  logic flushFetch;
  logic flushDecode;
  logic writeEnable;
  regAddrT writeAddr;
  wordT writeData;
  logic pcEnable;
  idExT decodeOut;
  logic decodeValid;
  wordT pc;

  int seed = 10609;
  int errorCount = 0;
  int checkCount = 0;
  int testCount = 0;
  int testErrors = 0;
  string testName = "reset";

  // model state
  // updated at each rising edge
  wordT modelReg [regCount];
  wordT modelPc;
  logic mFetchValid;
  instrT mFetchInstr;
  ctrlWordT mFetchCtrl;
  wordT mFetchPc;
  logic mDecodeValid;
  idExT mDecodeOut;

  decodeFrontEnd #(
    .pcStep(pcStep)
  ) u_dut (
    .clk        (clk),
    .clr        (clr),
    .fetchInstr (fetchInstr),
    .fetchValid (fetchValid),
    .fetchCtrl  (fetchCtrl),
    .stall      (stall),
    .flushFetch (flushFetch),
    .flushDecode(flushDecode),
    .writeEnable(writeEnable),
    .writeAddr  (writeAddr),
    .writeData  (writeData),
    .pcEnable   (pcEnable),
    .decodeOut  (decodeOut),
    .decodeValid(decodeValid),
    .pc         (pc)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #5 clk = ~clk;
  end

  // architectural register read
  // r15 returns the model pc
  function automatic wordT readModel(input regAddrT addr);
    if (addr == regAddrT'(pcIndex))
      return modelPc;
    else
      return modelReg[addr];
  endfunction

  // expected decode/execute payload for an instruction read now
  function automatic idExT expectDecode(input instrT instr, input ctrlWordT ctrl,
                                        input wordT fetchPc);
    idExT e;
    e.pc = fetchPc;
    e.cond = instr.cond;
    e.sBit = instr.sBit;
    e.rd = instr.rd;
    e.opA = readModel(instr.rn);
    e.opB = readModel(instr.operand2[3:0]);
    e.opD = readModel(instr.rd);
    e.operand2 = instr.operand2;
    e.ctrl = ctrl;
    return e;
  endfunction

  // cycle model of both stages
  // operand reads see the registers before this edge's write
  always @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      for (int i = 0; i < regCount; i++)
        modelReg[i] = '0;
      modelPc = '0;
      mFetchValid = 1'b0;
      mFetchInstr = '0;
      mFetchCtrl = '0;
      mFetchPc = '0;
      mDecodeValid = 1'b0;
      mDecodeOut = '0;
    end
    else
    begin
      // decode/execute stage
      // flush beats stall
      if (flushDecode)
        mDecodeValid = 1'b0;
      else if (!stall)
      begin
        mDecodeValid = mFetchValid;
        mDecodeOut = expectDecode(mFetchInstr, mFetchCtrl, mFetchPc);
      end
      // fetch/decode stage
      if (flushFetch)
        mFetchValid = 1'b0;
      else if (!stall)
      begin
        mFetchValid = fetchValid;
        mFetchInstr = fetchInstr;
        mFetchCtrl = fetchCtrl;
        mFetchPc = modelPc;
      end
      // writeback
      // a pc write wins over the step
      if (writeEnable && writeAddr != regAddrT'(pcIndex))
        modelReg[writeAddr] = writeData;
      if (writeEnable && writeAddr == regAddrT'(pcIndex))
        modelPc = writeData;
      else if (pcEnable)
        modelPc = modelPc + wordT'(pcStep);
    end
  end

  task automatic compareDecode(input string what, input idExT expected, input idExT actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("error %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic compareWord(input string what, input wordT expected, input wordT actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("error %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic compareBit(input string what, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("error %s %s: expected %b, actual %b", testName, what, expected, actual);
    end
  endtask

  // outputs are settled mid-cycle
  always @(negedge clk)
  begin
    if (clr)
    begin
      compareBit("decodeValid", mDecodeValid, decodeValid);
      if (mDecodeValid)
        compareDecode("decodeOut", mDecodeOut, decodeOut);
      compareWord("pc", modelPc, pc);
    end
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic wordT randWord();
    wordT w;
    w = $random(seed);
    return w;
  endfunction

  task automatic idleInputs();
    fetchInstr = '0;
    fetchValid = 1'b0;
    fetchCtrl = '0;
    stall = 1'b0;
    flushFetch = 1'b0;
    flushDecode = 1'b0;
    writeEnable = 1'b0;
    writeAddr = '0;
    writeData = '0;
    pcEnable = 1'b0;
  endtask

  task automatic presentRandom(input logic valid);
    wordT r;
    r = randWord();
    fetchInstr = randWord();
    fetchCtrl = r[12:0];
    fetchValid = valid;
  endtask

  task automatic startTest(input string name);
    testName = name;
    testErrors = errorCount;
  endtask

  // let the pipe empty before reporting
  task automatic endTest();
    idleInputs();
    repeat (drainCycles)
      tick();
    testCount++;
    $display("test %s finished, %0d errors", testName, errorCount - testErrors);
  endtask

  task automatic checkReset();
    startTest("reset");
    compareWord("pc after reset", '0, pc);
    compareBit("valid after reset", 1'b0, decodeValid);
    endTest();
  endtask

  task automatic stepPc();
    wordT startPc;
    startTest("pcStep");
    startPc = modelPc;
    pcEnable = 1'b1;
    repeat (stepCycles)
      tick();
    compareWord("pc after stepping", startPc + wordT'(stepCycles * pcStep), pc);
    pcEnable = 1'b0;
    repeat (holdCycles)
      tick();
    compareWord("pc on hold", startPc + wordT'(stepCycles * pcStep), pc);
    endTest();
  endtask

  task automatic writePc();
    wordT loadValue;
    startTest("pcWrite");
    loadValue = randWord();
    // write and step in the same cycle
    pcEnable = 1'b1;
    writeEnable = 1'b1;
    writeAddr = regAddrT'(pcIndex);
    writeData = loadValue;
    tick();
    compareWord("pc after write", loadValue, pc);
    idleInputs();
    // all three operands point at r15
    fetchInstr.rn = regAddrT'(pcIndex);
    fetchInstr.rd = regAddrT'(pcIndex);
    fetchInstr.operand2 = 12'h00f;
    fetchValid = 1'b1;
    tick();
    fetchValid = 1'b0;
    tick();
    compareWord("r15 read in decode", loadValue, decodeOut.opA);
    endTest();
  endtask

  task automatic decodeOperands();
    startTest("operands");
    for (int i = 0; i < pcIndex; i++)
    begin
      writeEnable = 1'b1;
      writeAddr = regAddrT'(i);
      writeData = randWord();
      tick();
    end
    writeEnable = 1'b0;
    for (int n = 0; n < operandCount; n++)
    begin
      presentRandom(1'b1);
      tick();
      fetchValid = 1'b0;
      tick();
    end
    endTest();
  endtask

  // each cycle writes the rn being read in decode
  task automatic streamBackToBack();
    instrT lastInstr;
    startTest("backToBack");
    lastInstr = '0;
    pcEnable = 1'b1;
    for (int n = 0; n < flowCycles; n++)
    begin
      presentRandom(1'b1);
      writeEnable = (n > 0);
      writeAddr = lastInstr.rn;
      writeData = randWord();
      lastInstr = fetchInstr;
      tick();
    end
    endTest();
  endtask

  task automatic stallAndFlush();
    wordT r;
    startTest("stallFlush");
    for (int n = 0; n < stallCycles; n++)
    begin
      r = randWord();
      presentRandom(r[0] | r[1]);
      stall = (r[4:3] == 2'b00);
      flushFetch = (r[7:5] == 3'b000);
      flushDecode = (r[10:8] == 3'b000);
      writeEnable = r[11];
      writeAddr = r[15:12];
      writeData = randWord();
      pcEnable = r[16];
      tick();
    end
    endTest();
  endtask

  initial
  begin
    idleInputs();
    clr = 1'b0;
    repeat (resetCycles)
      tick();
    clr = 1'b1;
    checkReset();
    stepPc();
    writePc();
    decodeOperands();
    streamBackToBack();
    stallAndFlush();
    errorCount += u_dut.u_asserts.failCount;
    $display("%0d tests, %0d checks, %0d assertion failures, %0d errors", testCount,
             checkCount, u_dut.u_asserts.failCount, errorCount);
    if (errorCount == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    #(watchdogCycles * 10);
    $display("timeout, tests did not finish within %0d cycles", watchdogCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: verilog/archPkg.sv
//========================================
// architectural widths and types shared by the decode front end
// import into any block that handles words, addresses or instructions
//========================================

package archPkg;

  // word width of the datapath
  parameter int unsigned dataWidth = 32;

  // register bank size
  parameter int unsigned regCount = 16;

  // register that holds the program counter
  parameter int unsigned pcIndex = 15;

  // one data word
  typedef logic [dataWidth-1:0] wordT;

  // register number, wide enough for the whole bank
  typedef logic [$clog2(regCount)-1:0] regAddrT;

  // instruction subfields
  typedef logic [3:0] condT;
  typedef logic [2:0] opClassT;
  typedef logic [3:0] opcodeT;
  typedef logic [11:0] operand2T;

  // instruction layout from the msb down
  typedef struct packed {
    condT     cond;
    opClassT  opClass;
    opcodeT   opcode;
    logic     sBit;
    regAddrT  rn;
    regAddrT  rd;
    // low nibble doubles as rm
    operand2T operand2;
  } instrT;

  // rm sits in the bottom nibble of operand2
  function automatic regAddrT rmOf(input instrT instr);
    regAddrT rm;
    rm = instr.operand2[$bits(regAddrT)-1:0];
    return rm;
  endfunction

endpackage

// File: verilog/decodeFrontEnd.sv
//========================================
// decode front end top level
// fetch/decode stage, register file reads, decode/execute stage
//========================================

`timescale 1ns/1ps

module decodeFrontEnd import archPkg::*; import pipePkg::*; #(
  // pc increment, passed to the register file
  parameter int unsigned pcStep = 4
) (
  input  logic     clk,
  input  logic     clr,
  // fetch side
  input  instrT    fetchInstr,
  input  logic     fetchValid,
  input  ctrlWordT fetchCtrl,
  // pipeline control
  input  logic     stall,
  input  logic     flushFetch,
  input  logic     flushDecode,
  // writeback port
  input  logic     writeEnable,
  input  regAddrT  writeAddr,
  input  wordT     writeData,
  input  logic     pcEnable,
  // toward execute
  output idExT     decodeOut,
  output logic     decodeValid,
  output wordT     pc
);

  // fetch/decode stage in and out
  ifIdT fetchPayload;
  ifIdT fetchHeld;
  logic fetchHeldValid;

  // operand values from the register file
  wordT rnData;
  wordT rmData;
  wordT rdData;

  // decode/execute stage input
  idExT decodePayload;

  // fetched instruction tagged with the pc it was fetched at
  always_comb
  begin
    fetchPayload.pc    = pc;
    fetchPayload.instr = fetchInstr;
    fetchPayload.ctrl  = fetchCtrl;
  end

  pipeStage #(
    .payloadT(ifIdT)
  ) fetchStage (
    .clk     (clk),
    .clr     (clr),
    .stall   (stall),
    .flush   (flushFetch),
    .inValid (fetchValid),
    .inData  (fetchPayload),
    .outValid(fetchHeldValid),
    .outData (fetchHeld)
  );

  // read addresses come straight from the held instruction
  registerFile #(
    .pcStep(pcStep)
  ) regs (
    .clk        (clk),
    .clr        (clr),
    .writeEnable(writeEnable),
    .writeAddr  (writeAddr),
    .writeData  (writeData),
    .pcEnable   (pcEnable),
    .readAddrA  (fetchHeld.instr.rn),
    .readAddrB  (rmOf(fetchHeld.instr)),
    .readAddrD  (fetchHeld.instr.rd),
    .readDataA  (rnData),
    .readDataB  (rmData),
    .readDataD  (rdData),
    .pc         (pc)
  );

  // held fields plus operands
  always_comb
  begin
    decodePayload.pc       = fetchHeld.pc;
    decodePayload.cond     = fetchHeld.instr.cond;
    decodePayload.sBit     = fetchHeld.instr.sBit;
    decodePayload.rd       = fetchHeld.instr.rd;
    decodePayload.opA      = rnData;
    decodePayload.opB      = rmData;
    decodePayload.opD      = rdData;
    decodePayload.operand2 = fetchHeld.instr.operand2;
    decodePayload.ctrl     = fetchHeld.ctrl;
  end

  pipeStage #(
    .payloadT(idExT)
  ) decodeStage (
    .clk     (clk),
    .clr     (clr),
    .stall   (stall),
    .flush   (flushDecode),
    .inValid (fetchHeldValid),
    .inData  (decodePayload),
    .outValid(decodeValid),
    .outData (decodeOut)
  );

endmodule

// File: verilog/pipePkg.sv
//========================================
// control word and stage payload layouts
// the stage registers carry these structs between fetch and execute
//========================================

package pipePkg;

  import archPkg::*;

  // alu operation select
  typedef logic [3:0] aluOpT;

  // data memory access size
  typedef logic [1:0] memModeT;

  // second operand source select
  typedef logic [1:0] reg2SelT;

  // 13-bit control word from the control unit
  // fields listed from the msb down
  typedef struct packed {
    logic    shiftImm;
    aluOpT   aluOp;
    logic    loadInst;
    logic    rfEnable;
    logic    nextReg1;
    logic    nextReg2;
    reg2SelT nextReg2Sel;
    memModeT memMode;
  } ctrlWordT;

  // fetch/decode payload
  // pc as it was when the instruction was fetched
  typedef struct packed {
    wordT     pc;
    instrT    instr;
    ctrlWordT ctrl;
  } ifIdT;

  // decode/execute payload
  typedef struct packed {
    wordT     pc;
    condT     cond;
    logic     sBit;
    regAddrT  rd;
    // value of rn
    wordT     opA;
    // value of rm
    wordT     opB;
    // value of rd for store data
    wordT     opD;
    operand2T operand2;
    ctrlWordT ctrl;
  } idExT;

endpackage

// File: verilog/pipeStage.sv
//========================================
// generic pipeline stage register
// typed by its payload, held by stall, valid killed by flush
//========================================

`timescale 1ns/1ps

module pipeStage #(
  // payload carried by this stage
  parameter type payloadT = logic [31:0]
) (
  input  logic    clk,
  input  logic    clr,
  // shared hold for the whole front end
  input  logic    stall,
  // drops the held entry at the next edge
  input  logic    flush,
  input  logic    inValid,
  input  payloadT inData,
  output logic    outValid,
  output payloadT outData
);

  // valid bit
  // flush overrides stall
  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      outValid <= 1'b0;
    end
    else if (flush)
    begin
      outValid <= 1'b0;
    end
    else if (!stall)
    begin
      outValid <= inValid;
    end
  end

  // payload
  // keeps its value on flush
  // only the valid goes away
  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      outData <= '0;
    end
    else if (!stall && !flush)
    begin
      outData <= inData;
    end
  end

endmodule

// File: verilog/registerFile.sv
//========================================
// sixteen-entry register bank with the pc living in the top entry
// one write port, three combinational read ports, no bypass
//========================================

`timescale 1ns/1ps

module registerFile import archPkg::*; #(
  // pc increment per enabled cycle
  parameter int unsigned pcStep = 4
) (
  input  logic    clk,
  input  logic    clr,
  // writeback port
  input  logic    writeEnable,
  input  regAddrT writeAddr,
  input  wordT    writeData,
  // pc advance enable
  input  logic    pcEnable,
  // read addresses
  input  regAddrT readAddrA,
  input  regAddrT readAddrB,
  input  regAddrT readAddrD,
  // read data as it was before the current edge
  output wordT    readDataA,
  output wordT    readDataB,
  output wordT    readDataD,
  output wordT    pc
);

  // one-hot write select, one bit per register
  logic [regCount-1:0] writeSel;

  // general registers r0..r14
  wordT generalReg [pcIndex];

  // r15
  wordT pcReg;

  // all sixteen entries as seen by the read ports
  wordT regView [regCount];

  // write decode
  // nothing selected unless the port is enabled
  always_comb
  begin
    writeSel = '0;
    if (writeEnable)
    begin
      writeSel[writeAddr] = 1'b1;
    end
  end

  // general registers
  // each loads writeData only on its own select bit
  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      for (int i = 0; i < pcIndex; i++)
      begin
        generalReg[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < pcIndex; i++)
      begin
        if (writeSel[i])
        begin
          generalReg[i] <= writeData;
        end
      end
    end
  end

  // pc register
  // an explicit write wins over the increment
  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      pcReg <= '0;
    end
    else if (writeSel[pcIndex])
    begin
      pcReg <= writeData;
    end
    else if (pcEnable)
    begin
      pcReg <= pcReg + wordT'(pcStep);
    end
  end

  // flat view for the read selectors
  // top entry is the pc itself
  always_comb
  begin
    for (int i = 0; i < pcIndex; i++)
    begin
      regView[i] = generalReg[i];
    end
    regView[pcIndex] = pcReg;
  end

  // three independent read selectors
  assign readDataA = regView[readAddrA];
  assign readDataB = regView[readAddrB];
  assign readDataD = regView[readAddrD];

  // current pc for the fetch side
  assign pc = pcReg;

endmodule
